// File: src/plru_cfg_pkg.sv
//==========================================================
// PLRU configuration package
// Size limits, default parameters and the way defeature
// encoding shared by the replacement tracker
//==========================================================
`default_nettype none

package plru_cfg_pkg;

   //==========================================================
   // Size limits and defaults
   //==========================================================
   localparam int LRU_MAX_WAYS       = 16;  // Largest tree the functions handle

   localparam int DEF_NUM_SETS       = 16;
   localparam int DEF_NUM_WAYS       = 8;
   localparam int DEF_NUM_PORTS      = 2;   // Parallel write ports
   localparam int DEF_NUM_PIPE_STAGE = 2;   // Read latency in cycles

   //==========================================================
   // Way defeature
   //==========================================================
   // Steers reads into a subset of the ways
   typedef enum logic [1:0] {
      DIS_NONE    = 2'b00,
      DIS_QUARTER = 2'b01,  // Upper half limited to its lower quarter
      DIS_HALF    = 2'b10   // Lower half only
   } disable_ways_e;

endpackage

`default_nettype wire

// File: src/plru_tree_pkg.sv
//==========================================================
// PLRU tree package
// Write opcode and recursive helpers that move between a
// pseudo-LRU tree and one-hot way vectors
//==========================================================
`default_nettype none

package plru_tree_pkg;

   import plru_cfg_pkg::*;

   // Write opcode of one port
   typedef enum logic [1:0] {
      WR_NONE      = 2'b00,
      WR_HIT       = 2'b01,
      WR_REPLACE   = 2'b10,
      WR_INVAL_ALL = 2'b11
   } wr_kind_e;

   //==========================================================
   // Tree layout
   //==========================================================
   // Bit 0 is the root, lower subtree in bits 1..num_ways/2-1,
   // upper subtree from bit num_ways/2 on. Same layout again
   // inside each subtree. Node value 0 points at the lower half

   // Walks the tree down to the LRU way
   function automatic logic [LRU_MAX_WAYS-1:0] f_tree_to_way(
      input logic [LRU_MAX_WAYS-2:0] tree,
      input int                      num_ways
   );
      int                      half;
      logic [LRU_MAX_WAYS-1:0] sub_way;

      if (num_ways < 2) begin
         return {{(LRU_MAX_WAYS-1){1'b0}}, 1'b1};  // Single way left
      end
      half = num_ways / 2;
      if (!tree[0]) begin
         sub_way = f_tree_to_way(tree >> 1, half);
         return sub_way;
      end
      sub_way = f_tree_to_way(tree >> half, half);
      return sub_way << half;
   endfunction

   // Nodes on the path of the accessed way
   function automatic logic [LRU_MAX_WAYS-2:0] f_way_to_mask(
      input logic [LRU_MAX_WAYS-1:0] way,
      input int                      num_ways
   );
      int                      half;
      logic [LRU_MAX_WAYS-1:0] half_sel;
      logic [LRU_MAX_WAYS-1:0] lo_way;
      logic [LRU_MAX_WAYS-1:0] hi_way;

      if (num_ways < 2) begin
         return '0;
      end
      half     = num_ways / 2;
      half_sel = ~({LRU_MAX_WAYS{1'b1}} << half);
      lo_way   = way & half_sel;
      hi_way   = (way >> half) & half_sel;
      if (|lo_way) begin
         return (f_way_to_mask(lo_way, half) << 1) | 1'b1;
      end
      if (|hi_way) begin
         return (f_way_to_mask(hi_way, half) << half) | 1'b1;
      end
      return '0;  // No way selected
   endfunction

   // Path nodes turned away from the accessed way
   function automatic logic [LRU_MAX_WAYS-2:0] f_way_to_data(
      input logic [LRU_MAX_WAYS-1:0] way,
      input int                      num_ways
   );
      int                      half;
      logic [LRU_MAX_WAYS-1:0] half_sel;
      logic [LRU_MAX_WAYS-1:0] lo_way;
      logic [LRU_MAX_WAYS-1:0] hi_way;

      if (num_ways < 2) begin
         return '0;
      end
      half     = num_ways / 2;
      half_sel = ~({LRU_MAX_WAYS{1'b1}} << half);
      lo_way   = way & half_sel;
      hi_way   = (way >> half) & half_sel;
      if (|lo_way) begin
         return (f_way_to_data(lo_way, half) << 1) | 1'b1;  // Point up
      end
      if (|hi_way) begin
         return f_way_to_data(hi_way, half) << half;         // Root stays 0
      end
      return '0;
   endfunction

endpackage

`default_nettype wire

// File: src/plru_port_update.sv
//==========================================================
// PLRU write port decoder
// Classifies one write port and builds its tree mask/data
//==========================================================
`timescale 1ns/100ps
`default_nettype none

module plru_port_update
   import plru_cfg_pkg::*;
   import plru_tree_pkg::*;
#(
   parameter int NUM_WAYS = DEF_NUM_WAYS
)(
   input  logic                wr_en,
   input  logic [NUM_WAYS-1:0] hit_vec,
   input  logic [NUM_WAYS-1:0] rep_vec,
   output wr_kind_e            wr_kind,
   output logic [NUM_WAYS-2:0] tree_mask,
   output logic [NUM_WAYS-2:0] tree_data
);

   logic [NUM_WAYS-1:0]     sel_vec;   // Way vector driving the update
   logic [LRU_MAX_WAYS-1:0] sel_full;
   logic [LRU_MAX_WAYS-2:0] path_mask;
   logic [LRU_MAX_WAYS-2:0] path_data;

   // Priority classification
   always_comb begin
      sel_vec = '0;
      if (!wr_en) begin
         wr_kind = WR_NONE;
      end else if (&rep_vec) begin
         wr_kind = WR_INVAL_ALL;
      end else if (~|hit_vec) begin
         wr_kind = WR_REPLACE;
         sel_vec = rep_vec;
      end else begin
         wr_kind = WR_HIT;
         sel_vec = hit_vec;
      end
   end

   assign sel_full  = LRU_MAX_WAYS'(sel_vec);
   assign path_mask = f_way_to_mask(sel_full, NUM_WAYS);
   assign path_data = f_way_to_data(sel_full, NUM_WAYS);

   // Invalidate clears the whole tree
   assign tree_mask = (wr_kind == WR_INVAL_ALL) ? '1 : path_mask[NUM_WAYS-2:0];
   assign tree_data = (wr_kind == WR_INVAL_ALL) ? '0 : path_data[NUM_WAYS-2:0];

   // One way per update, except invalidate
   always_comb begin
      if (wr_en && (wr_kind != WR_INVAL_ALL)) begin
         assert final ($onehot(sel_vec))
         else $error("plru_port_update: write vector %0h is not one-hot", sel_vec);
      end
   end

endmodule

`default_nettype wire

// File: src/plru_state_array.sv
//==========================================================
// PLRU state array
// One tree per set, masked writes from all ports merged,
// registered read set with a combinational tree lookup
//==========================================================
`timescale 1ns/100ps
`default_nettype none

module plru_state_array
   import plru_cfg_pkg::*;
   import plru_tree_pkg::*;
#(
   parameter  int NUM_SETS  = DEF_NUM_SETS,
   parameter  int NUM_WAYS  = DEF_NUM_WAYS,
   parameter  int NUM_PORTS = DEF_NUM_PORTS,
   localparam int SET_W     = (NUM_SETS > 1) ? $clog2(NUM_SETS) : 1
)(
   input  logic                                clk,
   input  logic                                rst_n,
   input  wr_kind_e [NUM_PORTS-1:0]            wr_kind,
   input  logic     [NUM_PORTS-1:0][SET_W-1:0] wr_set,
   input  logic [NUM_PORTS-1:0][NUM_WAYS-2:0]  tree_mask,
   input  logic [NUM_PORTS-1:0][NUM_WAYS-2:0]  tree_data,
   input  logic                                rd_en,
   input  logic [SET_W-1:0]                    rd_set,
   output logic [NUM_WAYS-2:0]                 rd_tree
);

   logic [NUM_SETS-1:0][NUM_WAYS-2:0] tree_q;    // Tree storage
   logic [NUM_SETS-1:0][NUM_WAYS-2:0] set_mask;  // Merged per-set mask
   logic [NUM_SETS-1:0][NUM_WAYS-2:0] set_data;
   logic [SET_W-1:0]                  rd_set_q;
   logic                              port_conflict;

   //==========================================================
   // Write path
   //==========================================================
   always_comb begin
      set_mask = '0;
      set_data = '0;
      for (int s = 0; s < NUM_SETS; s++) begin
         for (int p = 0; p < NUM_PORTS; p++) begin
            if ((wr_kind[p] != WR_NONE) && (wr_set[p] == SET_W'(s))) begin
               set_mask[s] |= tree_mask[p];
               set_data[s] |= tree_data[p];
            end
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tree_q <= '0;  // All sets point at way 0
      end else begin
         for (int s = 0; s < NUM_SETS; s++) begin
            tree_q[s] <= (tree_q[s] & ~set_mask[s]) | (set_data[s] & set_mask[s]);
         end
      end
   end

   //==========================================================
   // Read path
   //==========================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_set_q <= '0;
      end else if (rd_en) begin
         rd_set_q <= rd_set;
      end
   end

   assign rd_tree = tree_q[rd_set_q];  // Sees writes from the same edge

   // Two active ports on one set
   always_comb begin
      port_conflict = 1'b0;
      for (int p = 0; p < NUM_PORTS; p++) begin
         for (int q = p + 1; q < NUM_PORTS; q++) begin
            if ((wr_kind[p] != WR_NONE) && (wr_kind[q] != WR_NONE) &&
                (wr_set[p] == wr_set[q])) begin
               port_conflict = 1'b1;
            end
         end
      end
   end

   a_no_port_conflict : assert property (@(posedge clk) disable iff (!rst_n)
      !port_conflict)
   else $error("plru_state_array: two write ports hit the same set");

   a_rd_set_range : assert property (@(posedge clk) disable iff (!rst_n)
      rd_en |-> (int'(rd_set) < NUM_SETS))
   else $error("plru_state_array: read set %0d out of range", rd_set);

endmodule

`default_nettype wire

// File: src/plru_read_pipe.sv
//==========================================================
// PLRU read pipeline
// Invert and defeature steering on the looked-up tree,
// staged result and one-hot decode of LRU and 2nd way
//==========================================================
`timescale 1ns/100ps
`default_nettype none

module plru_read_pipe
   import plru_cfg_pkg::*;
   import plru_tree_pkg::*;
#(
   parameter int NUM_WAYS       = DEF_NUM_WAYS,
   parameter int NUM_PIPE_STAGE = DEF_NUM_PIPE_STAGE  // Minimum 1
)(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                rd_en,
   input  logic                rd_invert,
   input  disable_ways_e       disable_ways,
   input  logic [NUM_WAYS-2:0] rd_tree,
   output logic                rd_valid,
   output logic [NUM_WAYS-1:0] rd_way_vec,
   output logic [NUM_WAYS-1:0] rd_way_2nd_vec
);

   // Root of the upper subtree
   localparam int QTR_BIT = (NUM_WAYS >= 4) ? NUM_WAYS / 2 : 0;

   logic                    rd_en_q;
   logic                    invert_q;
   logic [NUM_WAYS-2:0]     look_tree;
   logic                    stg_vld  [1:NUM_PIPE_STAGE];
   logic [NUM_WAYS-2:0]     stg_tree [1:NUM_PIPE_STAGE];
   logic [NUM_WAYS-2:0]     fin_tree;
   logic [NUM_WAYS-2:0]     fin_tree_2nd;
   logic [LRU_MAX_WAYS-1:0] way_full;
   logic [LRU_MAX_WAYS-1:0] way_2nd_full;

   //==========================================================
   // Lookup stage
   //==========================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_en_q  <= 1'b0;
         invert_q <= 1'b0;
      end else begin
         rd_en_q  <= rd_en;
         invert_q <= rd_invert;  // Sampled with the request
      end
   end

   always_comb begin
      look_tree = rd_tree;
      if (invert_q) look_tree[0] = ~look_tree[0];   // B2B writes to one set
      // Defeature wins over invert
      if (disable_ways == DIS_HALF)    look_tree[0]       = 1'b0;
      if (disable_ways == DIS_QUARTER) look_tree[QTR_BIT] = 1'b0;
   end

   assign stg_vld[1]  = rd_en_q;
   assign stg_tree[1] = look_tree;

   //==========================================================
   // Extra latency stages
   //==========================================================
   for (genvar g = 1; g < NUM_PIPE_STAGE; g++) begin : g_stage
      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) begin
            stg_vld[g+1]  <= 1'b0;
            stg_tree[g+1] <= '0;
         end else begin
            stg_vld[g+1] <= stg_vld[g];
            if (stg_vld[g]) stg_tree[g+1] <= stg_tree[g];  // Hold when idle
         end
      end
   end

   //==========================================================
   // Way decode
   //==========================================================
   assign fin_tree = stg_tree[NUM_PIPE_STAGE];

   always_comb begin
      fin_tree_2nd    = fin_tree;
      fin_tree_2nd[0] = ~fin_tree[0];  // Other half of the root
   end

   assign way_full     = f_tree_to_way((LRU_MAX_WAYS-1)'(fin_tree), NUM_WAYS);
   assign way_2nd_full = f_tree_to_way((LRU_MAX_WAYS-1)'(fin_tree_2nd), NUM_WAYS);

   assign rd_valid       = stg_vld[NUM_PIPE_STAGE];
   assign rd_way_vec     = way_full[NUM_WAYS-1:0];
   assign rd_way_2nd_vec = way_2nd_full[NUM_WAYS-1:0];

endmodule

`default_nettype wire

// File: src/devtlb_plru.sv
//==========================================================
// Device TLB tree pseudo-LRU tracker
// Multi-port write decode, per-set tree state and a
// pipelined read port returning LRU and 2nd candidate
//==========================================================
`timescale 1ns/100ps
`default_nettype none

module devtlb_plru
   import plru_cfg_pkg::*;
   import plru_tree_pkg::*;
#(
   parameter  int NUM_SETS       = DEF_NUM_SETS,
   parameter  int NUM_WAYS       = DEF_NUM_WAYS,
   parameter  int NUM_PORTS      = DEF_NUM_PORTS,
   parameter  int NUM_PIPE_STAGE = DEF_NUM_PIPE_STAGE,
   localparam int SET_W          = (NUM_SETS > 1) ? $clog2(NUM_SETS) : 1
)(
   input  logic                               clk,
   input  logic                               rst_n,
   // Read port
   input  logic                               rd_en,
   input  logic [SET_W-1:0]                   rd_set,
   input  logic                               rd_invert,
   input  disable_ways_e                      disable_ways,
   // Write ports
   input  logic [NUM_PORTS-1:0]               wr_en,
   input  logic [NUM_PORTS-1:0][SET_W-1:0]    wr_set,
   input  logic [NUM_PORTS-1:0][NUM_WAYS-1:0] wr_hit_vec,
   input  logic [NUM_PORTS-1:0][NUM_WAYS-1:0] wr_rep_vec,
   // Read result
   output logic                               rd_valid,
   output logic [NUM_WAYS-1:0]                rd_way_vec,
   output logic [NUM_WAYS-1:0]                rd_way_2nd_vec
);

   wr_kind_e [NUM_PORTS-1:0]           port_kind;
   logic [NUM_PORTS-1:0][NUM_WAYS-2:0] port_mask;
   logic [NUM_PORTS-1:0][NUM_WAYS-2:0] port_data;
   logic [NUM_WAYS-2:0]                rd_tree;

   // Tree functions need a power of two within range
   if ((NUM_WAYS < 2) || (NUM_WAYS > LRU_MAX_WAYS) ||
       ((NUM_WAYS & (NUM_WAYS - 1)) != 0) || (NUM_PIPE_STAGE < 1)) begin : g_bad_cfg
      $error("devtlb_plru: unsupported NUM_WAYS %0d or NUM_PIPE_STAGE %0d",
             NUM_WAYS, NUM_PIPE_STAGE);
   end

   // One decoder per write port
   for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
      plru_port_update #(
         .NUM_WAYS (NUM_WAYS)
      ) u_port_update (
         .wr_en     (wr_en[p]),
         .hit_vec   (wr_hit_vec[p]),
         .rep_vec   (wr_rep_vec[p]),
         .wr_kind   (port_kind[p]),
         .tree_mask (port_mask[p]),
         .tree_data (port_data[p])
      );
   end

   plru_state_array #(
      .NUM_SETS  (NUM_SETS),
      .NUM_WAYS  (NUM_WAYS),
      .NUM_PORTS (NUM_PORTS)
   ) u_state_array (
      .clk       (clk),
      .rst_n     (rst_n),
      .wr_kind   (port_kind),
      .wr_set    (wr_set),
      .tree_mask (port_mask),
      .tree_data (port_data),
      .rd_en     (rd_en),
      .rd_set    (rd_set),
      .rd_tree   (rd_tree)
   );

   plru_read_pipe #(
      .NUM_WAYS       (NUM_WAYS),
      .NUM_PIPE_STAGE (NUM_PIPE_STAGE)
   ) u_read_pipe (
      .clk            (clk),
      .rst_n          (rst_n),
      .rd_en          (rd_en),
      .rd_invert      (rd_invert),
      .disable_ways   (disable_ways),
      .rd_tree        (rd_tree),
      .rd_valid       (rd_valid),
      .rd_way_vec     (rd_way_vec),
      .rd_way_2nd_vec (rd_way_2nd_vec)
   );

endmodule

`default_nettype wire

// File: tb/tb_devtlb_plru.sv
//==========================================================
// Testbench for the device TLB pseudo-LRU tracker
// Replays per-cycle vectors from a data file and checks
// the pipelined LRU and 2nd candidate results
//==========================================================
`timescale 1ns/100ps
`default_nettype none

module tb_devtlb_plru import plru_cfg_pkg::*; ();

   localparam int NUM_SETS       = DEF_NUM_SETS;
   localparam int NUM_WAYS       = DEF_NUM_WAYS;
   localparam int NUM_PORTS      = DEF_NUM_PORTS;
   localparam int NUM_PIPE_STAGE = DEF_NUM_PIPE_STAGE;
   localparam int SET_W          = (NUM_SETS > 1) ? $clog2(NUM_SETS) : 1;
   localparam int CLK_PERIOD     = 40;
   localparam int RESET_CYCLES   = 4;
   localparam int MAX_LINES      = 256;
   localparam int VEC_W          = 84;   // 21 hex digits per vector line
   localparam     VEC_FILE       = "tb/plru_input_vectors.txt";

   logic                               clk;
   logic                               rst_n;
   logic                               rd_en;
   logic [SET_W-1:0]                   rd_set;
   logic                               rd_invert;
   disable_ways_e                      disable_ways;
   logic [NUM_PORTS-1:0]               wr_en;
   logic [NUM_PORTS-1:0][SET_W-1:0]    wr_set;
   logic [NUM_PORTS-1:0][NUM_WAYS-1:0] wr_hit_vec;
   logic [NUM_PORTS-1:0][NUM_WAYS-1:0] wr_rep_vec;
   logic                               rd_valid;
   logic [NUM_WAYS-1:0]                rd_way_vec;
   logic [NUM_WAYS-1:0]                rd_way_2nd_vec;

   logic [VEC_W-1:0] vec_mem [0:MAX_LINES-1];  // Unloaded entries stay X
   int               num_lines   = 0;
   int               cur_line    = -1;         // -1 while in reset
   int               cycle_cnt   = 0;
   int               cycle_limit = 0;

   devtlb_plru #(
      .NUM_SETS       (NUM_SETS),
      .NUM_WAYS       (NUM_WAYS),
      .NUM_PORTS      (NUM_PORTS),
      .NUM_PIPE_STAGE (NUM_PIPE_STAGE)
   ) dut0 (
      .clk            (clk),
      .rst_n          (rst_n),
      .rd_en          (rd_en),
      .rd_set         (rd_set),
      .rd_invert      (rd_invert),
      .disable_ways   (disable_ways),
      .wr_en          (wr_en),
      .wr_set         (wr_set),
      .wr_hit_vec     (wr_hit_vec),
      .wr_rep_vec     (wr_rep_vec),
      .rd_valid       (rd_valid),
      .rd_way_vec     (rd_way_vec),
      .rd_way_2nd_vec (rd_way_2nd_vec)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   //==========================================================
   // Helpers
   //==========================================================
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("MISMATCH %s: got 0x%0h expected 0x%0h at line %0d",
                             name, got, exp, cur_line));
      end
   endtask

   task automatic idle_inputs();
      rd_en        = 1'b0;
      rd_set       = '0;
      rd_invert    = 1'b0;
      disable_ways = DIS_NONE;
      wr_en        = '0;
      wr_set       = '0;
      wr_hit_vec   = '0;
      wr_rep_vec   = '0;
   endtask

   // Field positions follow the column order of the data file
   task automatic drive_line(input logic [VEC_W-1:0] vec);
      rd_en         = vec[80];
      rd_set        = vec[76 +: SET_W];
      rd_invert     = vec[72];
      disable_ways  = disable_ways_e'(vec[68 +: 2]);
      wr_en[0]      = vec[64];
      wr_set[0]     = vec[60 +: SET_W];
      wr_hit_vec[0] = vec[52 +: 8];
      wr_rep_vec[0] = vec[44 +: 8];
      wr_en[1]      = vec[40];
      wr_set[1]     = vec[36 +: SET_W];
      wr_hit_vec[1] = vec[28 +: 8];
      wr_rep_vec[1] = vec[20 +: 8];
   endtask

   task automatic check_line(input logic [VEC_W-1:0] vec);
      check_value("rd_valid", rd_valid, vec[16]);
      if (vec[16]) begin  // Way vectors only mean something when valid
         check_value("rd_way_vec", rd_way_vec, vec[8 +: 8]);
         check_value("rd_way_2nd_vec", rd_way_2nd_vec, vec[0 +: 8]);
      end
   endtask

   //==========================================================
   // Watchdog
   //==========================================================
   always @(posedge clk) begin
      cycle_cnt++;
      if ((cycle_limit > 0) && (cycle_cnt > cycle_limit)) begin
         abort_run($sformatf("Timeout after %0d cycles, the run did not finish",
                             cycle_limit));
      end
   end

   //==========================================================
   // Main sequence
   //==========================================================
   initial begin
      int fd;

      rst_n = 1'b0;
      idle_inputs();

      fd = $fopen(VEC_FILE, "r");
      if (fd == 0) begin
         abort_run("Cannot open the stimulus file tb/plru_input_vectors.txt");
      end
      $fclose(fd);
      $readmemh(VEC_FILE, vec_mem);
      while ((num_lines < MAX_LINES) && !$isunknown(vec_mem[num_lines])) begin
         num_lines++;
      end
      if (num_lines == 0) begin
         abort_run("The stimulus file holds no readable vector lines");
      end
      cycle_limit = num_lines + NUM_PIPE_STAGE + 20;

      repeat (RESET_CYCLES) begin
         @(posedge clk);
         #1;
         check_value("rd_valid", rd_valid, 1'b0);  // Held low in reset
      end
      rst_n = 1'b1;

      // One vector line per clock cycle
      for (int i = 0; i < num_lines; i++) begin
         @(posedge clk);
         #1;
         cur_line = i;
         drive_line(vec_mem[i]);
         @(negedge clk);
         check_line(vec_mem[i]);
      end

      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: devtlb_plru.f
src/plru_cfg_pkg.sv
src/plru_tree_pkg.sv
src/plru_port_update.sv
src/plru_state_array.sv
src/plru_read_pipe.sv
src/devtlb_plru.sv
tb/tb_devtlb_plru.sv

// File: Bender.yml
package:
  name: devtlb_plru

sources:
  # Packages first, then the RTL bottom up
  - src/plru_cfg_pkg.sv
  - src/plru_tree_pkg.sv
  - src/plru_port_update.sv
  - src/plru_state_array.sv
  - src/plru_read_pipe.sv
  - src/devtlb_plru.sv
  - target: test
    files:
      - tb/tb_devtlb_plru.sv

// File: tb/plru_input_vectors.txt
// rd_en rd_set rd_invert disable_ways _ wr_en0 wr_set0 hit0 rep0 _ wr_en1 wr_set1 hit1 rep1
// _ exp_valid exp_way exp_2nd ; expected fields are the read output seen in this cycle
// Reads after reset, all sets point at way 0
1_0_0_0_0_0_00_00_0_0_00_00_0_00_00
1_9_0_0_0_0_00_00_0_0_00_00_0_00_00
1_f_0_0_0_0_00_00_0_0_00_00_1_01_10
// Hits to ways 0 4 2 6 on set 3, read in the same cycle
1_3_0_0_1_3_01_00_0_0_00_00_1_01_10
1_3_0_0_1_3_10_00_0_0_00_00_1_01_10
1_3_0_0_1_3_04_00_0_0_00_00_1_10_04
1_3_0_0_1_3_40_00_0_0_00_00_1_04_40
// Misses on set 5 through port 1, then invalidate
1_5_0_0_0_0_00_00_1_5_00_01_1_40_02
1_5_0_0_0_0_00_00_1_5_00_10_1_02_20
1_5_0_0_0_0_00_00_0_0_00_00_1_10_04
1_5_0_0_1_5_00_ff_0_0_00_00_1_04_40
// Both ports on different sets in one cycle
1_7_0_0_1_7_08_00_1_8_00_20_1_04_40
1_a_0_0_1_9_01_00_1_a_02_00_1_01_10
1_8_0_0_0_0_00_00_0_0_00_00_1_10_01
1_9_0_0_0_0_00_00_0_0_00_00_1_10_04
// Root invert
1_3_1_0_0_0_00_00_0_0_00_00_1_01_40
1_8_1_0_0_0_00_00_0_0_00_00_1_10_04
0_0_0_0_0_0_00_00_0_0_00_00_1_20_02
// Lower half only
0_0_0_2_0_0_00_00_0_0_00_00_1_40_01
1_3_0_2_0_0_00_00_0_0_00_00_0_00_00
1_8_1_2_0_0_00_00_0_0_00_00_0_00_00
0_0_0_2_0_0_00_00_0_0_00_00_1_02_20
// Upper half limited to ways 4 and 5
0_0_0_1_0_0_00_00_0_0_00_00_1_01_40
1_8_1_1_0_0_00_00_0_0_00_00_0_00_00
1_3_1_1_0_0_00_00_0_0_00_00_0_00_00
// Invalidate wins over a hit vector
1_3_0_1_1_3_02_ff_0_0_00_00_1_10_01
0_0_0_0_0_0_00_00_0_0_00_00_1_20_02
0_0_0_0_0_0_00_00_0_0_00_00_1_01_10
0_0_0_0_0_0_00_00_0_0_00_00_0_00_00
